/* motion_ctrl_top.f */
+incdir+hdl
hdl/motion_pkg.sv
hdl/move_if.sv
hdl/cmd_decoder.sv
hdl/move_buffer.sv
hdl/tick_divider.sv
hdl/dda_stepper.sv
hdl/motion_ctrl_top.sv
dv/motion_monitor.sv
dv/motion_ctrl_checker.sv
dv/motion_ctrl_tb.sv

/* Bender.yml */
package:
  name: motion_ctrl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/motion_pkg.sv
      - hdl/move_if.sv
      - hdl/cmd_decoder.sv
      - hdl/move_buffer.sv
      - hdl/tick_divider.sv
      - hdl/dda_stepper.sv
      - hdl/motion_ctrl_top.sv
  - target: test
    files:
      - dv/motion_monitor.sv
      - dv/motion_ctrl_checker.sv
      - dv/motion_ctrl_tb.sv

/* dv/motion_cases.txt */
# name kind a b c d expect (a..d hex, expect decimal)
# move: a=dir b=duration c=increment d=incinc; sync: a=toggles; halt: a=toggles b=delay c=length
ver0 ver 0 0 0 0 0
en1 en 1 0 0 0 0
m1 move 1 8 40000000 0 4
s1 sync 1 0 0 0 0
div1 div 1 0 0 0 0
m2 move 0 a 0 10000000 5
s2 sync 2 0 0 0 0
raw0 raw 5500000000000000 0 0 0 0
div3 div 3 0 0 0 0
b1 move 1 64 40000000 0 50
b2 move 0 64 40000000 0 50
b3 move 1 64 40000000 0 50
b4 move 0 64 40000000 0 50
b5 move 1 64 40000000 0 50
hm move 1 3e8 0 0 0
h1 halt 7 1e 5 0 0
en0 en 0 0 0 0 0
m3 move 1 6 40000000 0 3
s3 sync 8 0 0 0 0
ver1 ver 0 0 0 0 0

/* dv/motion_ctrl_tb.sv */
`default_nettype none

`include "motion_params.svh"

module motion_ctrl_tb;

  import motion_pkg::*;

  logic CLK, resetn, word_valid, halt;
  logic [63:0] word_data, reply_data;
  logic step, dir, enable, buffer_room, move_done;
  logic [127:0] case_name;
  logic [31:0] case_expect;

  logic [127:0] names [32];
  logic [63:0] kinds [32];
  logic [63:0] op_a [32], op_b [32], op_c [32], op_d [32];
  int expect_val [32];
  int n_cases;
  logic [31:0] lfsr;
  int toggles = 0;
  logic md_last = 1'b0;
  longint limit;
  bit limit_set = 0;

  motion_ctrl_top dut0 (
    .CLK(CLK), .resetn(resetn), .word_valid(word_valid), .word_data(word_data),
    .halt(halt), .reply_data(reply_data), .step(step), .dir(dir), .enable(enable),
    .buffer_room(buffer_room), .move_done(move_done)
  );

  motion_monitor mon0 (
    .CLK(CLK), .resetn(resetn), .word_valid(word_valid), .word_data(word_data),
    .halt(halt), .reply_data(reply_data), .step(step), .dir(dir), .enable(enable),
    .buffer_room(buffer_room), .move_done(move_done), .case_name(case_name),
    .case_expect(case_expect)
  );

  initial CLK = 1'b0;
  always #4 CLK = ~CLK;

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'ha3000000) : (s >> 1);
  endfunction

  task idle_gap();
    int gap;
    gap = 0;
    for (int k = 0; k < 3; k++) begin
      gap = gap | (int'(lfsr[0]) << k);
      lfsr = lfsr_next(lfsr);
    end
    repeat (gap) @(negedge CLK);
  endtask

  task send_word(input logic [63:0] w);
    @(negedge CLK);
    word_valid = 1'b1;
    word_data = w;
    @(negedge CLK);
    word_valid = 1'b0;
    idle_gap();
  endtask

  task send_move(input int i);
    while (!buffer_room) @(negedge CLK);
    send_word({CMD_COORDINATED_STEP, 55'd0, op_a[i][0]});
    send_word(op_b[i]);
    send_word(op_c[i]);
    send_word(op_d[i]);
    repeat (2) @(negedge CLK); // Let the push reach the room flag
  endtask

  task wait_toggles(input longint n);
    while (toggles < n) @(toggles);
  endtask

  always @(negedge CLK) begin
    if (move_done === 1'b0 || move_done === 1'b1) begin
      if (move_done != md_last) toggles++;
      md_last = move_done;
    end
  end

  // Watchdog sized from the case list
  initial begin
    wait (limit_set);
    repeat (limit) @(posedge CLK);
    $display("Watchdog expired after %0d cycles", limit);
    $display("Test failed");
    $finish;
  end

  initial begin
    int fd;
    string line;
    logic [63:0] div;
    int total;
    resetn = 1'b0;
    word_valid = 1'b0;
    word_data = '0;
    halt = 1'b0;
    case_name = "reset";
    case_expect = '0;
    lfsr = 32'heec989a2;
    n_cases = 0;
    fd = $fopen("dv/motion_cases.txt", "r");
    if (fd == 0) begin
      $display("Cannot open case file dv/motion_cases.txt");
      $display("Test failed");
      $finish;
    end else begin
      while (!$feof(fd) && n_cases < 32) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() > 1 && line[0] != "#") begin
          if ($sscanf(line, "%s %s %h %h %h %h %d", names[n_cases], kinds[n_cases],
                      op_a[n_cases], op_b[n_cases], op_c[n_cases], op_d[n_cases],
                      expect_val[n_cases]) == 7) n_cases++;
        end
      end
      $fclose(fd);
      div = 3;
      limit = 16;
      for (int i = 0; i < n_cases; i++) begin
        limit += 200;
        if (kinds[i] == "div") div = op_a[i];
        if (kinds[i] == "move") limit += (div + 1) * op_b[i];
      end
      limit_set = 1;
      repeat (8) @(negedge CLK);
      resetn = 1'b1;
      for (int i = 0; i < n_cases; i++) begin
        case_name = names[i];
        case_expect = expect_val[i];
        if (kinds[i] == "move") send_move(i);
        else if (kinds[i] == "ver") send_word({CMD_API_VERSION, 56'd0});
        else if (kinds[i] == "en") send_word({CMD_MOTOR_ENABLE, 55'd0, op_a[i][0]});
        else if (kinds[i] == "div") send_word({CMD_CLK_DIVISOR, 48'd0, op_a[i][7:0]});
        else if (kinds[i] == "raw") send_word(op_a[i]);
        else if (kinds[i] == "sync") wait_toggles(op_a[i]);
        else if (kinds[i] == "halt") begin
          wait_toggles(op_a[i]);
          repeat (op_b[i]) @(negedge CLK);
          halt = 1'b1;
          repeat (op_c[i]) @(negedge CLK);
          halt = 1'b0;
        end else begin
          $display("ERROR: unknown case kind in case %0s", names[i]);
          mon0.errors++;
        end
      end
      repeat (20) @(negedge CLK);
      mon0.final_check();
      total = mon0.errors + dut0.chk0.fails;
      $display("%0d cases, %0d cycles checked, %0d check errors, %0d assertion errors",
               n_cases, mon0.checks, mon0.errors, dut0.chk0.fails);
      if (total == 0) begin
        $display("Test passed");
      end else begin
        $display("Test failed");
      end
      $finish;
    end
  end

endmodule

`default_nettype wire

/* dv/motion_ctrl_checker.sv */
`default_nettype none

module motion_ctrl_checker (
  input wire logic CLK,
  input wire logic resetn,
  input wire logic halt,
  input wire logic step,
  input wire logic step_pulse,
  input wire logic move_done,
  input wire logic push,
  input wire logic room
);

  int fails = 0;

  // Registered pulse must be gone once halt has been seen for an edge
  a_no_step_in_halt: assert property (@(posedge CLK) disable iff (!resetn)
    $past(halt) |-> !step_pulse)
    else begin
      fails++;
      $error("step pulse generated while halt is high");
    end

  a_no_push_when_full: assert property (@(posedge CLK) disable iff (!resetn) push |-> room)
    else begin
      fails++;
      $error("move pushed into a full buffer");
    end

  a_step_low_in_reset: assert property (@(posedge CLK) !resetn |=> !step)
    else begin
      fails++;
      $error("step high during reset");
    end

  a_no_done_in_halt: assert property (@(posedge CLK) disable iff (!resetn)
    halt |=> $stable(move_done))
    else begin
      fails++;
      $error("move_done toggled during halt");
    end

endmodule

bind motion_ctrl_top motion_ctrl_checker chk0 (
  .CLK(CLK), .resetn(resetn), .halt(halt), .step(step), .step_pulse(stp0.step_q),
  .move_done(move_done), .push(wr_mv.push), .room(buffer_room)
);

`default_nettype wire

/* dv/motion_monitor.sv */
`default_nettype none

`include "motion_params.svh"

module motion_monitor (
  input wire logic         CLK,
  input wire logic         resetn,
  input wire logic         word_valid,
  input wire logic [63:0]  word_data,
  input wire logic         halt,
  input wire logic [63:0]  reply_data,
  input wire logic         step,
  input wire logic         dir,
  input wire logic         enable,
  input wire logic         buffer_room,
  input wire logic         move_done,
  input wire logic [127:0] case_name,
  input wire logic [31:0]  case_expect
);

  import motion_pkg::*;

  localparam longint THRESHOLD = `STEP_THRESHOLD;
  localparam logic [63:0] VERSION_WORD = {40'd0, `VERSION_MAJOR, `VERSION_MINOR, `VERSION_PATCH};

  int errors = 0;
  int checks = 0;
  longint cyc = 0;
  bit rst_q, halt_q;
  int data_left;
  logic [63:0] exp_reply, w_dur;
  logic exp_enable, w_dir;
  logic [7:0] exp_div;
  longint w_inc, w_incinc;
  logic [127:0] cur_name; // Case name as seen at the last edge

  // Moves written but not yet finished, head is the one running
  bit q_dir[$];
  logic [63:0] q_dur[$];
  longint q_inc[$], q_incinc[$], q_edge[$];
  int q_exp[$];
  logic [127:0] q_name[$];

  longint acc, done_cycle, last_done;
  bit active, last_md;
  int steps, model_steps;

  task value_error(input logic [127:0] name, input string what, input longint e, input longint a);
    errors++;
    $display("CHECK FAILED %0s %0s expected %0h actual %0h", name, what, e, a);
  endtask

  task plain_error(input string msg);
    errors++;
    $display("ERROR: %0s during case %0s", msg, cur_name);
  endtask

  task final_check();
    if (active || q_dir.size() != 0) plain_error("moves still queued at end of run");
  endtask

  task clear_queue();
    q_dir.delete();
    q_dur.delete();
    q_inc.delete();
    q_incinc.delete();
    q_edge.delete();
    q_exp.delete();
    q_name.delete();
  endtask

  task pop_head();
    void'(q_dir.pop_front());
    void'(q_dur.pop_front());
    void'(q_inc.pop_front());
    void'(q_incinc.pop_front());
    void'(q_edge.pop_front());
    void'(q_exp.pop_front());
    void'(q_name.pop_front());
  endtask

  // Command word tracking, sampled where the DUT samples
  always @(posedge CLK) begin
    cyc++;
    rst_q = resetn;
    halt_q = halt;
    cur_name = case_name;
    if (!resetn) begin
      data_left = 0;
      exp_reply = '0;
      exp_enable = 1'b0;
      exp_div = 8'd3;
      acc = 0;
      active = 0;
      last_done = 0;
      steps = 0;
      last_md = 1'b0;
      clear_queue();
    end else if (word_valid) begin
      if (data_left == 0) begin
        exp_reply = (word_data[63:56] == CMD_API_VERSION) ? VERSION_WORD : '0;
        case (word_data[63:56])
          CMD_COORDINATED_STEP: begin
            data_left = 3;
            w_dir = word_data[0];
          end
          CMD_MOTOR_ENABLE: exp_enable = word_data[0];
          CMD_CLK_DIVISOR:  exp_div = word_data[7:0];
          default: ;
        endcase
      end else begin
        exp_reply = '0;
        case (data_left)
          3: w_dur = word_data;
          2: w_inc = word_data;
          default: begin
            w_incinc = word_data;
            q_dir.push_back(w_dir);
            q_dur.push_back(w_dur);
            q_inc.push_back(w_inc);
            q_incinc.push_back(w_incinc);
            q_edge.push_back(cyc);
            q_exp.push_back(case_expect);
            q_name.push_back(case_name);
          end
        endcase
        data_left--;
      end
    end
  end

  always @(negedge CLK) begin
    longint inc;
    longint k;
    int written;
    bit done_now;
    bit toggled;
    if (rst_q) begin
      checks++;
      if (reply_data !== exp_reply) value_error(cur_name, "reply_data", exp_reply, reply_data);
      if (enable !== exp_enable) value_error(cur_name, "enable", exp_enable, enable);
      if (halt_q) begin // Everything queued is dropped
        clear_queue();
        active = 0;
        steps = 0;
        last_done = 0;
      end
      if (step === 1'b1) begin
        steps++;
        if (!active) plain_error("step pulse with no move running");
        else if (dir !== q_dir[0]) value_error(q_name[0], "dir", q_dir[0], dir);
      end
      done_now = active && (cyc == done_cycle);
      toggled = (move_done !== last_md);
      last_md = move_done;
      if (toggled && !done_now) plain_error("move_done toggled when no move was due");
      if (!toggled && done_now) plain_error("move_done missing at end of move");
      if (done_now) begin
        if (steps != model_steps) value_error(q_name[0], "step count", model_steps, steps);
        pop_head();
        active = 0;
        last_done = cyc;
        steps = 0;
      end
      // Load edge is two after the last word, or one after the previous move
      if (!active && q_dir.size() > 0 && cyc >= q_edge[0] + 2 && cyc >= last_done + 1) begin
        active = 1;
        steps = 0;
        inc = q_inc[0];
        model_steps = 0;
        for (k = 0; k < longint'(q_dur[0]); k++) begin
          acc = acc + inc;
          inc = inc + q_incinc[0]; // Ramp after the add
          if (acc >= THRESHOLD) begin
            acc = acc - THRESHOLD;
            model_steps++;
          end
        end
        if (model_steps != q_exp[0]) plain_error("case file step count differs from model");
        done_cycle = cyc + longint'(q_dur[0]) * (longint'(exp_div) + 1);
      end
      written = 0;
      foreach (q_edge[i]) if (q_edge[i] + 1 <= cyc) written++;
      if (buffer_room !== (written < 4)) begin
        value_error(cur_name, "buffer_room", written < 4, buffer_room);
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/motion_ctrl_top.sv */
`default_nettype none

`include "motion_params.svh"

module motion_ctrl_top (
  input  wire logic                  CLK,
  input  wire logic                  resetn,
  input  wire logic                  word_valid,
  input  wire logic [`WORD_BITS-1:0] word_data,
  input  wire logic                  halt,
  output logic [`WORD_BITS-1:0]      reply_data,
  output logic                       step,
  output logic                       dir,
  output logic                       enable,
  output logic                       buffer_room,
  output logic                       move_done
);

  logic [7:0] clock_divisor;
  logic       pending;
  logic       take;
  logic       tick;
  logic       run;

  move_if wr_mv ();  // Decoder into the ring
  move_if rd_mv ();  // Ring head to the stepper

  cmd_decoder dec0 (
    .CLK           (CLK),
    .resetn        (resetn),
    .word_valid    (word_valid),
    .word_data     (word_data),
    .reply_data    (reply_data),
    .enable        (enable),
    .clock_divisor (clock_divisor),
    .mv            (wr_mv.producer)
  );

  move_buffer buf0 (
    .CLK     (CLK),
    .resetn  (resetn),
    .halt    (halt),
    .wr      (wr_mv.consumer),
    .rd      (rd_mv.producer),
    .pending (pending),
    .take    (take),
    .room    (buffer_room)
  );

  tick_divider div0 (
    .CLK           (CLK),
    .resetn        (resetn),
    .run           (run),
    .clock_divisor (clock_divisor),
    .tick          (tick)
  );

  dda_stepper stp0 (
    .CLK       (CLK),
    .resetn    (resetn),
    .halt      (halt),
    .mv        (rd_mv.consumer),
    .pending   (pending),
    .take      (take),
    .tick      (tick),
    .run       (run),
    .step      (step),
    .dir       (dir),
    .move_done (move_done)
  );

endmodule

`default_nettype wire

/* hdl/dda_stepper.sv */
`default_nettype none

`include "motion_params.svh"

module dda_stepper (
  input  wire logic CLK,
  input  wire logic resetn,
  input  wire logic halt,
  move_if.consumer  mv,
  input  wire logic pending,
  output logic      take,
  input  wire logic tick,
  output logic      run,
  output logic      step,
  output logic      dir,
  output logic      move_done
);

  logic                         busy;
  logic [`WORD_BITS-1:0]        remaining;  // Ticks left in the move
  logic signed [`WORD_BITS-1:0] inc_q;      // Current ramped increment
  logic signed [`WORD_BITS-1:0] acc_q;      // Substep accumulator
  logic signed [`WORD_BITS-1:0] acc_sum;
  logic                         step_q;
  logic                         last_tick;

  assign acc_sum   = acc_q + inc_q;
  assign last_tick = (remaining <= 1);
  assign run       = busy;

  // Combinational so the cursor moves on the same edge the move ends
  assign take = busy && tick && last_tick && !halt;

  assign step = step_q && !halt;

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      busy      <= 1'b0;
      acc_q     <= '0;
      step_q    <= 1'b0;
      move_done <= 1'b0;
      dir       <= 1'b0;
    end else begin
      step_q <= 1'b0;
      if (halt) begin
        busy <= 1'b0; // Abandon, accumulator kept
      end else if (!busy) begin
        if (pending && mv.push) begin
          busy <= 1'b1;
          dir  <= mv.dir;
        end
      end else if (tick) begin
        if (acc_sum >= `STEP_THRESHOLD) begin
          acc_q  <= acc_sum - `STEP_THRESHOLD;
          step_q <= 1'b1;
        end else begin
          acc_q <= acc_sum;
        end
        if (last_tick) begin
          busy      <= 1'b0;
          move_done <= ~move_done;
        end
      end
    end
  end

  // Move payload
  always_ff @(posedge CLK) begin
    if (!busy) begin
      remaining <= mv.duration;
      inc_q     <= mv.increment;
    end else if (tick) begin
      remaining <= remaining - 1'b1;
      inc_q     <= inc_q + mv.incinc; // Second order ramp
    end
  end

endmodule

`default_nettype wire

/* hdl/tick_divider.sv */
`default_nettype none

`include "motion_params.svh"

module tick_divider (
  input  wire logic       CLK,
  input  wire logic       resetn,
  input  wire logic       run,
  input  wire logic [7:0] clock_divisor,
  output logic            tick
);

  logic [7:0] count;

  // Period is clock_divisor + 1 cycles
  assign tick = run && (count == 8'd0);

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      count <= `RESET_DIVISOR;
    end else if (!run) begin
      count <= clock_divisor; // Preload while idle
    end else if (count == 8'd0) begin
      count <= clock_divisor;
    end else begin
      count <= count - 8'd1;
    end
  end

endmodule

`default_nettype wire

/* hdl/move_buffer.sv */
`default_nettype none

`include "motion_params.svh"

module move_buffer (
  input  wire logic CLK,
  input  wire logic resetn,
  input  wire logic halt,
  move_if.consumer  wr,
  move_if.producer  rd,
  output logic      pending,
  input  wire logic take,
  output logic      room
);

  localparam int DEPTH = 1 << `MOVE_BUFFER_BITS;

  // Extra msb tells full from empty
  logic [`MOVE_BUFFER_BITS:0] wr_ptr;
  logic [`MOVE_BUFFER_BITS:0] rd_ptr;

  logic                         dir_mem    [DEPTH];
  logic [`WORD_BITS-1:0]        dur_mem    [DEPTH];
  logic signed [`WORD_BITS-1:0] inc_mem    [DEPTH];
  logic signed [`WORD_BITS-1:0] incinc_mem [DEPTH];

  logic empty;
  logic full;

  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr[`MOVE_BUFFER_BITS] != rd_ptr[`MOVE_BUFFER_BITS]) &&
                 (wr_ptr[`MOVE_BUFFER_BITS-1:0] == rd_ptr[`MOVE_BUFFER_BITS-1:0]);

  assign pending = !empty;
  assign room    = !full;

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (wr.push && !full) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (halt) begin
        rd_ptr <= wr_ptr; // Drop everything queued
      end else if (take && !empty) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (wr.push && !full) begin
      dir_mem[wr_ptr[`MOVE_BUFFER_BITS-1:0]]    <= wr.dir;
      dur_mem[wr_ptr[`MOVE_BUFFER_BITS-1:0]]    <= wr.duration;
      inc_mem[wr_ptr[`MOVE_BUFFER_BITS-1:0]]    <= wr.increment;
      incinc_mem[wr_ptr[`MOVE_BUFFER_BITS-1:0]] <= wr.incinc;
    end
  end

  // Head entry, usable only outside halt
  assign rd.push      = !empty && !halt;
  assign rd.dir       = dir_mem[rd_ptr[`MOVE_BUFFER_BITS-1:0]];
  assign rd.duration  = dur_mem[rd_ptr[`MOVE_BUFFER_BITS-1:0]];
  assign rd.increment = inc_mem[rd_ptr[`MOVE_BUFFER_BITS-1:0]];
  assign rd.incinc    = incinc_mem[rd_ptr[`MOVE_BUFFER_BITS-1:0]];

endmodule

`default_nettype wire

/* hdl/cmd_decoder.sv */
`default_nettype none

`include "motion_params.svh"

module cmd_decoder (
  input  wire logic                  CLK,
  input  wire logic                  resetn,
  input  wire logic                  word_valid,
  input  wire logic [`WORD_BITS-1:0] word_data,
  output logic [`WORD_BITS-1:0]      reply_data,
  output logic                       enable,
  output logic [7:0]                 clock_divisor,
  move_if.producer                   mv
);

  import motion_pkg::*;

  localparam logic [`WORD_BITS-1:0] VERSION_WORD = {
    {(`WORD_BITS-24){1'b0}}, `VERSION_MAJOR, `VERSION_MINOR, `VERSION_PATCH
  };

  dec_state_e state;
  cmd_op_e    header;

  assign header = cmd_op_e'(word_data[`WORD_BITS-1 -: 8]);

  // Control state, reply and settings
  always_ff @(posedge CLK) begin
    if (!resetn) begin
      state         <= S_HEADER;
      reply_data    <= '0;
      enable        <= 1'b0;
      clock_divisor <= `RESET_DIVISOR;
      mv.push       <= 1'b0;
    end else begin
      mv.push <= 1'b0; // One cycle strobe
      if (word_valid) begin
        reply_data <= '0;
        case (state)
          S_HEADER: begin
            case (header)
              CMD_COORDINATED_STEP: state <= S_DURATION;
              CMD_MOTOR_ENABLE:     enable <= word_data[0];
              CMD_CLK_DIVISOR:      clock_divisor <= word_data[7:0];
              CMD_API_VERSION:      reply_data <= VERSION_WORD;
              default: ;            // Unknown header dropped
            endcase
          end
          S_DURATION:  state <= S_INCREMENT;
          S_INCREMENT: state <= S_INCINC;
          S_INCINC: begin
            state   <= S_HEADER;
            mv.push <= 1'b1; // All three data words in
          end
          default: state <= S_HEADER;
        endcase
      end
    end
  end

  // Move fields, each captured on its own word
  always_ff @(posedge CLK) begin
    if (word_valid) begin
      case (state)
        S_HEADER: begin
          if (header == CMD_COORDINATED_STEP) begin
            mv.dir <= word_data[0];
          end
        end
        S_DURATION:  mv.duration <= word_data;
        S_INCREMENT: mv.increment <= word_data;
        S_INCINC:    mv.incinc <= word_data;
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

/* hdl/move_if.sv */
`default_nettype none

`include "motion_params.svh"

interface move_if;

  logic                         push;      // Entry strobe or entry live
  logic                         dir;
  logic [`WORD_BITS-1:0]        duration;  // In DDA ticks
  logic signed [`WORD_BITS-1:0] increment;
  logic signed [`WORD_BITS-1:0] incinc;    // Ramp added per tick

  modport producer (
    output push,
    output dir,
    output duration,
    output increment,
    output incinc
  );

  modport consumer (
    input push,
    input dir,
    input duration,
    input increment,
    input incinc
  );

endinterface

`default_nettype wire

/* hdl/motion_pkg.sv */
`default_nettype none

package motion_pkg;

  // Header byte, bits 63:56 of the first word of a command
  typedef enum logic [7:0] {
    CMD_COORDINATED_STEP = 8'h01,
    CMD_MOTOR_ENABLE     = 8'h0a,
    CMD_CLK_DIVISOR      = 8'h0b,
    CMD_API_VERSION      = 8'hfe
  } cmd_op_e;

  // Which word the decoder expects next
  typedef enum logic [1:0] {
    S_HEADER,
    S_DURATION,
    S_INCREMENT,
    S_INCINC
  } dec_state_e;

endpackage

`default_nettype wire

/* hdl/motion_params.svh */
`ifndef MOTION_PARAMS_SVH
`define MOTION_PARAMS_SVH

// Host command word width
`define WORD_BITS 64

// Ring buffer address bits, 4 entries
`define MOVE_BUFFER_BITS 2

// Substep accumulator level that produces one step
`define STEP_THRESHOLD 64'sd2147483648

`define RESET_DIVISOR 8'd3

`define VERSION_MAJOR 8'd0
`define VERSION_MINOR 8'd3
`define VERSION_PATCH 8'd1

`endif
